/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_decode_stage
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+tests
source/rv_isa_pkg.sv
source/decode_pkg.sv
source/instr_decoder.sv
source/operand_select.sv
source/fence_tracker.sv
source/decode_execute_latch.sv
source/decode_stage.sv
tests/tb_decode_stage.sv

/* source/decode_execute_latch.sv */
/*
  Decode to execute pipeline register. Holds under stall, loads a bubble
  on flush or when no valid instruction is present.
*/
`timescale 1ns/10ps
`default_nettype none

module decode_execute_latch (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   stall,
  input  logic                   flush,
  input  logic                   valid,
  input  decode_pkg::ctrl_t      ctrl,
  input  rv_isa_pkg::word_t      port_a,
  input  rv_isa_pkg::word_t      port_b,
  input  rv_isa_pkg::word_t      store_data,
  input  rv_isa_pkg::word_t      reg_file_wdata,
  input  rv_isa_pkg::word_t      immediate,
  input  decode_pkg::jump_sigs_t jump,
  output decode_pkg::dispatch_t  dispatch
);
  import decode_pkg::*;

  dispatch_t next_dispatch;

  always_comb begin
    next_dispatch = '0;
    if (valid) begin
      next_dispatch.valid          = 1'b1;
      next_dispatch.unit           = ctrl.unit;
      next_dispatch.alu_op         = ctrl.alu_op;
      next_dispatch.port_a         = port_a;
      next_dispatch.port_b         = port_b;
      next_dispatch.reg_file_wdata = reg_file_wdata;
      next_dispatch.immediate      = immediate;
      next_dispatch.rd             = ctrl.rd;
      next_dispatch.wen            = ctrl.wen;
      next_dispatch.branch_instr   = ctrl.branch;
      next_dispatch.branch_type    = ctrl.branch_type;
      next_dispatch.dren           = ctrl.dren;
      next_dispatch.dwen           = ctrl.dwen;
      next_dispatch.load_type      = ctrl.load_type;
      next_dispatch.halt           = ctrl.halt;
      next_dispatch.illegal        = ctrl.illegal;

      // Only jumps carry a target, only stores carry data
      if (ctrl.jump) begin
        next_dispatch.jump = jump;
      end
      if (ctrl.dwen) begin
        next_dispatch.store_data = store_data;
      end
    end
  end

  // Flush takes priority over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dispatch <= '0;
    end else if (flush) begin
      dispatch <= '0;
    end else if (!stall) begin
      dispatch <= next_dispatch;
    end
  end

endmodule

`default_nettype wire

/* source/decode_pkg.sv */
/*
  Decode stage types: fetch input, decoder control bundle, jump signals
  and the dispatch bundle registered toward execute, plus operand selects.
*/
`default_nettype none

package decode_pkg;
  import rv_isa_pkg::*;

  typedef enum logic [1:0] {A_RS1, A_IMM_S, A_PC, A_ZERO} src_a_sel_t;
  typedef enum logic [1:0] {B_RS1, B_RS2, B_IMM_SHAMT, B_IMM_U} src_b_sel_t;
  typedef enum logic [1:0] {W_NONE, W_PC4, W_IMM_U} w_src_t;
  typedef enum logic {ARITH_U, LSU_U} unit_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
    word_t pc4;
  } fetch_packet_t;

  // Raw decoder output, immediates not yet sign extended
  typedef struct packed {
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    logic [11:0] imm_I;
    logic [11:0] imm_S;
    logic [12:0] imm_SB;
    logic [20:0] imm_UJ;
    logic [19:0] imm_U;
    logic [4:0]  shamt;
    src_a_sel_t  src_a_sel;
    src_b_sel_t  src_b_sel;
    logic        imm_shamt_sel;
    logic        j_sel;
    logic        jump;
    logic        branch;
    funct3_t     branch_type;
    unit_t       unit;
    alu_op_t     alu_op;
    w_src_t      w_src;
    logic        wen;
    logic        dren;
    logic        dwen;
    funct3_t     load_type;
    logic        halt;
    logic        ifence;
    logic        illegal;
  } ctrl_t;

  typedef struct packed {
    word_t j_base;
    word_t j_offset;
    logic  jump_instr;
    logic  j_sel;
  } jump_sigs_t;

  // All zero is a bubble
  typedef struct packed {
    logic       valid;
    unit_t      unit;
    alu_op_t    alu_op;
    word_t      port_a;
    word_t      port_b;
    word_t      store_data;
    word_t      reg_file_wdata;
    word_t      immediate;
    reg_idx_t   rd;
    logic       wen;
    jump_sigs_t jump;
    logic       branch_instr;
    funct3_t    branch_type;
    logic       dren;
    logic       dwen;
    funct3_t    load_type;
    logic       halt;
    logic       illegal;
  } dispatch_t;

endpackage

`default_nettype wire

/* source/decode_stage.sv */
/*
  Decode stage top. Reads the register file through rs1_idx/rs2_idx,
  registers one decoded instruction per cycle into the dispatch bundle.
*/
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  logic                      CLK,
  input  logic                      nRST,
  input  decode_pkg::fetch_packet_t fetch,
  input  logic                      stall,
  input  logic                      flush,
  input  rv_isa_pkg::word_t         rs1_data,
  input  rv_isa_pkg::word_t         rs2_data,
  input  logic                      iflush_done,
  input  logic                      dflush_done,
  output rv_isa_pkg::reg_idx_t      rs1_idx,
  output rv_isa_pkg::reg_idx_t      rs2_idx,
  output decode_pkg::dispatch_t     dispatch,
  output logic                      icache_flush,
  output logic                      dcache_flush,
  output logic                      fence_pending
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  ctrl_t      ctrl;
  word_t      port_a;
  word_t      port_b;
  word_t      reg_file_wdata;
  word_t      immediate;
  jump_sigs_t jump;

  instr_decoder u_decoder (
    .instr (fetch.instr),
    .ctrl  (ctrl)
  );

  // Register file answers in the same cycle
  assign rs1_idx = ctrl.rs1;
  assign rs2_idx = ctrl.rs2;

  operand_select u_operands (
    .ctrl           (ctrl),
    .pc             (fetch.pc),
    .pc4            (fetch.pc4),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .port_a         (port_a),
    .port_b         (port_b),
    .reg_file_wdata (reg_file_wdata),
    .immediate      (immediate),
    .jump           (jump)
  );

  fence_tracker u_fence (
    .CLK           (CLK),
    .nRST          (nRST),
    .ifence_valid  (fetch.valid & ctrl.ifence),
    .stall         (stall),
    .iflush_done   (iflush_done),
    .dflush_done   (dflush_done),
    .icache_flush  (icache_flush),
    .dcache_flush  (dcache_flush),
    .fence_pending (fence_pending)
  );

  decode_execute_latch u_latch (
    .CLK            (CLK),
    .nRST           (nRST),
    .stall          (stall),
    .flush          (flush),
    .valid          (fetch.valid),
    .ctrl           (ctrl),
    .port_a         (port_a),
    .port_b         (port_b),
    .store_data     (rs2_data),
    .reg_file_wdata (reg_file_wdata),
    .immediate      (immediate),
    .jump           (jump),
    .dispatch       (dispatch)
  );

endmodule

`default_nettype wire

/* source/fence_tracker.sv */
/*
  fence.i handling. Turns a fence.i into a single flush strobe to both
  caches and keeps fence_pending high until both flushes are confirmed.
*/
`timescale 1ns/10ps
`default_nettype none

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic ifence_valid,
  input  logic stall,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic fence_pending
);

  logic ifence_prev;
  logic ifence_pulse;
  logic iflushed;
  logic dflushed;

  // Back-to-back fence.i instructions share one pulse
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifence_prev <= 1'b0;
    end else if (!stall) begin
      ifence_prev <= ifence_valid;
    end
  end

  assign ifence_pulse = ifence_valid && !ifence_prev && !stall;
  assign icache_flush = ifence_pulse;
  assign dcache_flush = ifence_pulse;

  // Done bits start set; a new pulse wins over a late done
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else if (ifence_pulse) begin
      iflushed <= 1'b0;
      dflushed <= 1'b0;
    end else if (!stall) begin
      iflushed <= iflushed | iflush_done;
      dflushed <= dflushed | dflush_done;
    end
  end

  assign fence_pending = !(iflushed && dflushed);

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
/*
  Combinational control unit. Splits an RV32I word into register fields
  and raw immediates and sets selects, unit, ALU operation and enables.
*/
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  rv_isa_pkg::word_t  instr,
  output decode_pkg::ctrl_t  ctrl
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  logic    alt_bit;
  alu_op_t alu_decoded;

  assign opcode  = opcode_t'(instr[OPCODE_W-1:0]);
  assign funct3  = instr[FUNCT3_LSB +: 3];
  assign alt_bit = instr[ALT_FUNCT_BIT];

  // Bit 30 picks SUB only for register ADD, but SRA for both shift forms
  always_comb begin
    case (funct3)
      3'b000:  alu_decoded = (alt_bit && opcode == OP) ? SUB : ADD;
      3'b001:  alu_decoded = SLL;
      3'b010:  alu_decoded = SLT;
      3'b011:  alu_decoded = SLTU;
      3'b100:  alu_decoded = XOR;
      3'b101:  alu_decoded = alt_bit ? SRA : SRL;
      3'b110:  alu_decoded = OR;
      default: alu_decoded = AND;
    endcase
  end

  always_comb begin
    ctrl = '0;

    // Fields that do not depend on the opcode
    ctrl.rs1         = instr[RS1_LSB +: REG_IDX_W];
    ctrl.rs2         = instr[RS2_LSB +: REG_IDX_W];
    ctrl.rd          = instr[RD_LSB +: REG_IDX_W];
    ctrl.imm_I       = instr[31:20];
    ctrl.imm_S       = {instr[31:25], instr[11:7]};
    ctrl.imm_SB      = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_UJ      = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_U       = instr[31:12];
    ctrl.shamt       = instr[RS2_LSB +: 5];
    ctrl.branch_type = funct3;
    ctrl.load_type   = funct3;

    case (opcode)
      LUI: begin
        ctrl.src_a_sel = A_ZERO;
        ctrl.src_b_sel = B_IMM_U;
        ctrl.w_src     = W_IMM_U;
        ctrl.wen       = 1'b1;
      end
      AUIPC: begin
        ctrl.src_a_sel = A_PC;
        ctrl.src_b_sel = B_IMM_U;
        ctrl.wen       = 1'b1;
      end
      JAL, JALR: begin
        ctrl.jump  = 1'b1;
        ctrl.j_sel = (opcode == JAL);
        ctrl.w_src = W_PC4;
        ctrl.wen   = 1'b1;
      end
      BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.src_b_sel = B_RS2;
      end
      LOAD: begin
        ctrl.unit = LSU_U;
        ctrl.dren = 1'b1;
        ctrl.wen  = 1'b1;
      end
      STORE: begin
        ctrl.unit      = LSU_U;
        ctrl.src_b_sel = B_RS2;
        ctrl.dwen      = 1'b1;
      end
      OP_IMM: begin
        ctrl.src_b_sel     = B_IMM_SHAMT;
        ctrl.imm_shamt_sel = (funct3 == 3'b001) || (funct3 == 3'b101);
        ctrl.alu_op        = alu_decoded;
        ctrl.wen           = 1'b1;
      end
      OP: begin
        ctrl.src_b_sel = B_RS2;
        ctrl.alu_op    = alu_decoded;
        ctrl.wen       = 1'b1;
      end
      MISC_MEM: begin
        // Plain fence needs nothing here
        ctrl.ifence = (funct3 == FUNCT3_FENCE_I);
      end
      default: begin
        if (instr == HALT_WORD) begin
          ctrl.halt = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/operand_select.sv */
/*
  Immediate sign extension and operand muxing for the decode stage.
  Also forms the jump base/offset pair and the early write-back value.
*/
`timescale 1ns/10ps
`default_nettype none

module operand_select (
  input  decode_pkg::ctrl_t      ctrl,
  input  rv_isa_pkg::word_t      pc,
  input  rv_isa_pkg::word_t      pc4,
  input  rv_isa_pkg::word_t      rs1_data,
  input  rv_isa_pkg::word_t      rs2_data,
  output rv_isa_pkg::word_t      port_a,
  output rv_isa_pkg::word_t      port_b,
  output rv_isa_pkg::word_t      reg_file_wdata,
  output rv_isa_pkg::word_t      immediate,
  output decode_pkg::jump_sigs_t jump
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  word_t imm_I_ext;
  word_t imm_S_ext;
  word_t imm_SB_ext;
  word_t imm_UJ_ext;
  word_t imm_U_word;
  word_t imm_or_shamt;

  assign imm_I_ext  = {{20{ctrl.imm_I[11]}}, ctrl.imm_I};
  assign imm_S_ext  = {{20{ctrl.imm_S[11]}}, ctrl.imm_S};
  assign imm_SB_ext = {{19{ctrl.imm_SB[12]}}, ctrl.imm_SB};
  assign imm_UJ_ext = {{11{ctrl.imm_UJ[20]}}, ctrl.imm_UJ};
  assign imm_U_word = {ctrl.imm_U, 12'b0};

  // Shift amounts are zero extended
  assign imm_or_shamt = ctrl.imm_shamt_sel ? {27'b0, ctrl.shamt} : imm_I_ext;

  always_comb begin
    case (ctrl.src_a_sel)
      A_RS1:   port_a = rs1_data;
      A_IMM_S: port_a = imm_S_ext;
      A_PC:    port_a = pc;
      default: port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.src_b_sel)
      B_RS1:       port_b = rs1_data;
      B_RS2:       port_b = rs2_data;
      B_IMM_SHAMT: port_b = imm_or_shamt;
      default:     port_b = imm_U_word;
    endcase
  end

  always_comb begin
    case (ctrl.w_src)
      W_PC4:   reg_file_wdata = pc4;
      W_IMM_U: reg_file_wdata = imm_U_word;
      default: reg_file_wdata = '0;
    endcase
  end

  // Offset for the LSU address, else the branch displacement
  always_comb begin
    if (ctrl.dwen) begin
      immediate = imm_S_ext;
    end else if (ctrl.dren) begin
      immediate = imm_I_ext;
    end else begin
      immediate = imm_SB_ext;
    end
  end

  // JAL is pc relative, JALR adds the I offset to rs1
  assign jump.j_base     = ctrl.j_sel ? pc : port_a;
  assign jump.j_offset   = ctrl.j_sel ? imm_UJ_ext : imm_I_ext;
  assign jump.jump_instr = ctrl.jump;
  assign jump.j_sel      = ctrl.j_sel;

endmodule

`default_nettype wire

/* source/rv_isa_pkg.sv */
/*
  RV32I definitions shared by the decode stage and its testbench.
  Word and register types, opcode and ALU operation encodings, field positions.
*/
`default_nettype none

package rv_isa_pkg;

  // Basic widths
  localparam int WORD_W    = 32;
  localparam int REG_IDX_W = 5;
  localparam int OPCODE_W  = 7;

  // Bit positions of the standard instruction fields
  localparam int RD_LSB        = 7;
  localparam int FUNCT3_LSB    = 12;
  localparam int RS1_LSB       = 15;
  localparam int RS2_LSB       = 20;
  localparam int ALT_FUNCT_BIT = 30;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [2:0]           funct3_t;

  typedef enum logic [OPCODE_W-1:0] {
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP       = 7'b0110011,
    MISC_MEM = 7'b0001111
  } opcode_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_op_t;

  // All-ones word is treated as halt
  localparam word_t HALT_WORD = 32'hFFFF_FFFF;

  // fence.i under MISC_MEM
  localparam funct3_t FUNCT3_FENCE_I = 3'b001;

endpackage

`default_nettype wire

/* tests/decode_vectors.svh */
/*
  Stimulus table for the decode stage testbench, included inside the testbench module.
  Each row is one instruction, its pc and the dispatch fields expected one cycle later.
*/
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Where an expected operand comes from
typedef enum logic [1:0] {K_CONST, K_RS1, K_RS2, K_PC} src_kind_t;

typedef struct {
  word_t     instr;
  word_t     pc;
  unit_t     unit;
  alu_op_t   alu_op;
  reg_idx_t  rd;
  logic      wen;
  logic      dren;
  logic      dwen;
  logic      jump;
  logic      halt;
  logic      illegal;
  src_kind_t a_kind;
  word_t     a_val;
  src_kind_t b_kind;
  word_t     b_val;
  word_t     wdata;
  src_kind_t jb_kind;
  word_t     j_offset;
} vec_row_t;

localparam int NUM_VECTORS = 14;

// Columns: instr, pc, unit, alu_op, rd, wen, dren, dwen, jump, halt, illegal,
//          port_a kind/value, port_b kind/value, wdata, jump base kind, jump offset
vec_row_t vectors [NUM_VECTORS] = '{
  '{32'h002081B3, 32'h00000010, ARITH_U, ADD, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS2, 32'h0, 32'h0, K_CONST, 32'h0},
  '{32'h40628233, 32'h00000014, ARITH_U, SUB, 5'd4, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS2, 32'h0, 32'h0, K_CONST, 32'h0},
  '{32'h409453B3, 32'h00000018, ARITH_U, SRA, 5'd7, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS2, 32'h0, 32'h0, K_CONST, 32'h0},
  '{32'h00C5B533, 32'h0000001C, ARITH_U, SLTU, 5'd10, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS2, 32'h0, 32'h0, K_CONST, 32'h0},
  '{32'hFFF74693, 32'h00000020, ARITH_U, XOR, 5'd13, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_CONST, 32'hFFFFFFFF, 32'h0, K_CONST, 32'h0},
  '{32'h00581793, 32'h00000024, ARITH_U, SLL, 5'd15, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_CONST, 32'h5, 32'h0, K_CONST, 32'h0},
  '{32'h123458B7, 32'h00000028, ARITH_U, ADD, 5'd17, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_CONST, 32'h0, K_CONST, 32'h12345000, 32'h12345000, K_CONST, 32'h0},
  '{32'hABCDE917, 32'h00000100, ARITH_U, ADD, 5'd18, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    K_PC, 32'h0, K_CONST, 32'hABCDE000, 32'h0, K_CONST, 32'h0},
  '{32'h010000EF, 32'h00000200, ARITH_U, ADD, 5'd1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS1, 32'h0, 32'h00000204, K_PC, 32'h10},
  '{32'h00830267, 32'h00000300, ARITH_U, ADD, 5'd4, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS1, 32'h0, 32'h00000304, K_RS1, 32'h8},
  '{32'hFFC4A403, 32'h00000400, LSU_U, ADD, 5'd8, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS1, 32'h0, 32'h0, K_CONST, 32'h0},
  '{32'h00A5A623, 32'h00000404, LSU_U, ADD, 5'd12, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
    K_RS1, 32'h0, K_RS2, 32'h0, 32'h0, K_CONST, 32'h0},
  '{32'h0000007F, 32'h00000408, ARITH_U, ADD, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
    K_RS1, 32'h0, K_RS1, 32'h0, 32'h0, K_CONST, 32'h0},
  '{32'hFFFFFFFF, 32'h0000040C, ARITH_U, ADD, 5'd31, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
    K_RS1, 32'h0, K_RS1, 32'h0, 32'h0, K_CONST, 32'h0}
};

`endif

/* tests/tb_decode_stage.sv */
/*
  Testbench for the decode stage. Applies the instruction table, then
  directed stall, flush, bubble and fence.i scenarios against a register file model.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;
  import rv_isa_pkg::*;
  import decode_pkg::*;

  `include "decode_vectors.svh"

  // Reset plus the directed scenarios after the table
  localparam int SCENARIO_CYCLES = 27;
  localparam int CYCLE_LIMIT     = 2 * NUM_VECTORS + SCENARIO_CYCLES + 20;
  localparam word_t FENCE_I_WORD = 32'h0000100F;

  logic          CLK;
  logic          nRST;
  fetch_packet_t fetch;
  logic          stall;
  logic          flush;
  word_t         rs1_data;
  word_t         rs2_data;
  logic          iflush_done;
  logic          dflush_done;
  reg_idx_t      rs1_idx;
  reg_idx_t      rs2_idx;
  dispatch_t     dispatch;
  logic          icache_flush;
  logic          dcache_flush;
  logic          fence_pending;

  word_t regs [32];
  int    cycles = 0;

  decode_stage UUT (
    .CLK           (CLK),
    .nRST          (nRST),
    .fetch         (fetch),
    .stall         (stall),
    .flush         (flush),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .iflush_done   (iflush_done),
    .dflush_done   (dflush_done),
    .rs1_idx       (rs1_idx),
    .rs2_idx       (rs2_idx),
    .dispatch      (dispatch),
    .icache_flush  (icache_flush),
    .dcache_flush  (dcache_flush),
    .fence_pending (fence_pending)
  );

  // Register file answers in the same cycle
  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic fetch_packet_t make_fetch(input word_t instr, input word_t pc);
    fetch_packet_t f;
    f.valid = 1'b1;
    f.instr = instr;
    f.pc    = pc;
    f.pc4   = pc + 32'd4;
    return f;
  endfunction

  // Expected operand from the instruction's own register fields
  function automatic word_t expand(input src_kind_t kind, input word_t val, input vec_row_t r);
    case (kind)
      K_RS1:   return regs[r.instr[19:15]];
      K_RS2:   return regs[r.instr[24:20]];
      K_PC:    return r.pc;
      default: return val;
    endcase
  endfunction

  task automatic report(input string name, input logic [255:0] got, input logic [255:0] exp);
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) report(name, 256'(got), 256'(exp));
  endtask

  task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) report(name, 256'(got), 256'(exp));
  endtask

  task automatic check_unit(input string name, input unit_t got, input unit_t exp);
    if (got !== exp) report(name, 256'(got), 256'(exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report(name, 256'(got), 256'(exp));
  endtask

  task automatic check_dispatch(input string name, input dispatch_t got, input dispatch_t exp);
    if (got !== exp) report(name, 256'(got), 256'(exp));
  endtask

  task automatic check_row(input vec_row_t r);
    word_t rs2v;
    rs2v = regs[r.instr[24:20]];
    check_bit("dispatch.valid", dispatch.valid, 1'b1);
    check_unit("dispatch.unit", dispatch.unit, r.unit);
    check_alu_op("dispatch.alu_op", dispatch.alu_op, r.alu_op);
    check_word("dispatch.rd", {27'b0, dispatch.rd}, {27'b0, r.rd});
    check_bit("dispatch.wen", dispatch.wen, r.wen);
    check_bit("dispatch.dren", dispatch.dren, r.dren);
    check_bit("dispatch.dwen", dispatch.dwen, r.dwen);
    check_bit("dispatch.halt", dispatch.halt, r.halt);
    check_bit("dispatch.illegal", dispatch.illegal, r.illegal);
    check_word("dispatch.port_a", dispatch.port_a, expand(r.a_kind, r.a_val, r));
    check_word("dispatch.port_b", dispatch.port_b, expand(r.b_kind, r.b_val, r));
    check_word("dispatch.reg_file_wdata", dispatch.reg_file_wdata, r.wdata);
    check_word("dispatch.store_data", dispatch.store_data, r.dwen ? rs2v : 32'h0);
    check_bit("dispatch.jump.jump_instr", dispatch.jump.jump_instr, r.jump);
    check_bit("dispatch.jump.j_sel", dispatch.jump.j_sel, r.jump && (r.jb_kind == K_PC));
    check_word("dispatch.jump.j_base", dispatch.jump.j_base,
               r.jump ? expand(r.jb_kind, 32'h0, r) : 32'h0);
    check_word("dispatch.jump.j_offset", dispatch.jump.j_offset, r.jump ? r.j_offset : 32'h0);
  endtask

  initial begin
    word_t state;
    CLK         = 1'b0;
    nRST        = 1'b0;
    fetch       = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    state       = 32'd84;
    regs[0]     = '0;
    for (int i = 1; i < 32; i++) begin
      state   = xorshift(state);
      regs[i] = state;
    end

    // Bubble out of reset and no flush activity
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    check_dispatch("dispatch", dispatch, '0);
    check_bit("icache_flush", icache_flush, 1'b0);
    check_bit("fence_pending", fence_pending, 1'b0);
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;

    for (int i = 0; i < NUM_VECTORS; i++) begin
      @(posedge CLK);
      fetch <= make_fetch(vectors[i].instr, vectors[i].pc);
      @(negedge CLK);
      check_word("rs1_idx", {27'b0, rs1_idx}, {27'b0, vectors[i].instr[19:15]});
      check_word("rs2_idx", {27'b0, rs2_idx}, {27'b0, vectors[i].instr[24:20]});
      @(posedge CLK);
      fetch <= '0;
      @(negedge CLK);
      check_row(vectors[i]);
    end

    // Stall holds the registered instruction while fetch has nothing valid
    @(posedge CLK);
    fetch <= make_fetch(vectors[0].instr, vectors[0].pc);
    @(posedge CLK);
    stall <= 1'b1;
    fetch <= '0;
    @(negedge CLK);
    check_row(vectors[0]);
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    check_row(vectors[0]);

    // Flush wins over stall
    @(posedge CLK);
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    stall <= 1'b0;
    fetch <= '0;
    @(negedge CLK);
    check_dispatch("dispatch", dispatch, '0);

    // Flush alone drops a valid instruction
    @(posedge CLK);
    fetch <= make_fetch(vectors[1].instr, vectors[1].pc);
    flush <= 1'b1;
    @(posedge CLK);
    fetch <= '0;
    flush <= 1'b0;
    @(negedge CLK);
    check_dispatch("dispatch", dispatch, '0);

    // No valid strobe gives a bubble
    @(posedge CLK);
    fetch <= make_fetch(vectors[2].instr, vectors[2].pc);
    @(posedge CLK);
    fetch <= '0;
    @(posedge CLK);
    @(negedge CLK);
    check_dispatch("dispatch", dispatch, '0);

    // fence.i twice in a row, then instruction cache done first
    @(posedge CLK);
    fetch <= make_fetch(FENCE_I_WORD, 32'h500);
    @(negedge CLK);
    check_bit("icache_flush", icache_flush, 1'b1);
    check_bit("dcache_flush", dcache_flush, 1'b1);
    @(posedge CLK);
    fetch <= make_fetch(FENCE_I_WORD, 32'h504);
    @(negedge CLK);
    check_bit("icache_flush", icache_flush, 1'b0);
    check_bit("dcache_flush", dcache_flush, 1'b0);
    check_bit("fence_pending", fence_pending, 1'b1);
    @(posedge CLK);
    fetch       <= '0;
    iflush_done <= 1'b1;
    @(posedge CLK);
    iflush_done <= 1'b0;
    @(negedge CLK);
    check_bit("fence_pending", fence_pending, 1'b1);
    @(posedge CLK);
    dflush_done <= 1'b1;
    @(posedge CLK);
    dflush_done <= 1'b0;
    @(negedge CLK);
    check_bit("fence_pending", fence_pending, 1'b0);

    // Data cache done first this time
    @(posedge CLK);
    fetch <= make_fetch(FENCE_I_WORD, 32'h600);
    @(negedge CLK);
    check_bit("icache_flush", icache_flush, 1'b1);
    @(posedge CLK);
    fetch       <= '0;
    dflush_done <= 1'b1;
    @(posedge CLK);
    dflush_done <= 1'b0;
    @(negedge CLK);
    check_bit("fence_pending", fence_pending, 1'b1);
    @(posedge CLK);
    iflush_done <= 1'b1;
    @(posedge CLK);
    iflush_done <= 1'b0;
    @(negedge CLK);
    check_bit("fence_pending", fence_pending, 1'b0);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
